// ==== include/bp_defs.svh ====
// Branch predictor sizing
`ifndef BP_DEFS_SVH
`define BP_DEFS_SVH

// Fetch address
`define BP_ADDR_W       32          // Byte address width

// Table geometry
`define BP_DEPTH        512         // Entries per table
`define BP_INDEX_W      9           // log2 of BP_DEPTH
`define BP_INDEX_LSB    2           // Index from pc[10:2]

// Partial tag above the index
`define BP_TAG_LSB      11          // First bit past the index
`define BP_TAG_W        12          // Tag from pc[22:11]

// Targets are word aligned, low two bits dropped
`define BP_TARGET_W     30          // Stored target width in words

`endif

// ==== hw/bp_pkg.sv ====
// Branch predictor types
`include "bp_defs.svh"

package bp_pkg;

    // Two bit saturating direction counter
    // 0,1 predict not taken and 2,3 predict taken
    // Upper bit alone gives the direction
    typedef logic [1:0] counter_t;

    // One target table entry, 43 bits packed
    typedef struct packed {
        logic                    valid;     // Entry written at least once
        logic [`BP_TAG_W-1:0]    tag;       // Partial tag of branch pc
        logic [`BP_TARGET_W-1:0] target;    // Target address in words
    } btb_entry_t;

endpackage

// ==== hw/bp_if.sv ====
// Branch predictor table bus
`timescale 1ns/100ps
`include "bp_defs.svh"

interface bp_if;

    // Fetch side lookup
    logic                   fetch_valid;        // One cycle lookup strobe
    logic [`BP_ADDR_W-1:0]  fetch_pc;           // Address being fetched

    // Execute side update
    logic                   update_valid;       // One cycle update strobe
    logic [`BP_ADDR_W-1:0]  update_pc;          // Resolved branch pc
    logic                   update_taken;       // Resolved direction
    logic [`BP_ADDR_W-1:0]  update_target;      // Resolved target, byte address
    bp_pkg::counter_t       update_counter;     // Counter reported with the prediction

    // Top level drives everything
    modport source (
        output fetch_valid,
        output fetch_pc,
        output update_valid,
        output update_pc,
        output update_taken,
        output update_target,
        output update_counter
    );

    // Both tables only listen
    modport tbl (
        input fetch_valid,
        input fetch_pc,
        input update_valid,
        input update_pc,
        input update_taken,
        input update_target,
        input update_counter
    );

endinterface

// ==== hw/branch_predictor_ram.sv ====
// Predictor table block RAM
`timescale 1ns/100ps
`include "bp_defs.svh"

module branch_predictor_ram #(
    parameter type payload_t = logic [7:0],     // Entry layout
    parameter int  DEPTH     = `BP_DEPTH        // Number of entries
) (
    input  logic                     clk,
    input  logic [$clog2(DEPTH)-1:0] write_addr,
    input  logic                     write_en,
    input  logic [$clog2(DEPTH)-1:0] read_addr,
    input  logic                     read_en,
    input  payload_t                 write_data,
    output payload_t                 read_data
);

    (* ram_style = "block" *) payload_t table_ram [DEPTH-1:0];   // Storage array

    // Tables start empty
    initial table_ram = '{default: '0};

    // Write port
    always_ff @(posedge clk) begin
        if (write_en) begin
            table_ram[write_addr] <= write_data;    // Visible from next edge on
        end
    end

    // Read port, separate process so a same-edge write is not seen
    always_ff @(posedge clk) begin
        if (read_en) begin
            read_data <= table_ram[read_addr];      // Old contents on collision
        end                                         // Holds while idle
    end

endmodule

// ==== hw/btb_lookup.sv ====
// Branch target table
`timescale 1ns/100ps
`include "bp_defs.svh"

module btb_lookup (
    input  logic                  clk,
    input  logic                  rst_n,
    bp_if.tbl                     bus,
    output logic                  btb_hit,
    output logic [`BP_ADDR_W-1:0] btb_target
);

    logic [`BP_INDEX_W-1:0] rd_index;       // Lookup row
    logic [`BP_INDEX_W-1:0] wr_index;       // Update row
    logic [`BP_TAG_W-1:0]   fetch_tag;      // Tag of incoming lookup
    logic [`BP_TAG_W-1:0]   fetch_tag_q;    // Tag aligned with RAM output
    logic                   wr_en;
    bp_pkg::btb_entry_t     wr_entry;
    bp_pkg::btb_entry_t     rd_entry;

    // Address slicing
    assign rd_index  = bus.fetch_pc[`BP_INDEX_LSB +: `BP_INDEX_W];
    assign wr_index  = bus.update_pc[`BP_INDEX_LSB +: `BP_INDEX_W];
    assign fetch_tag = bus.fetch_pc[`BP_TAG_LSB +: `BP_TAG_W];

    // Only taken branches allocate, no writes while in reset
    assign wr_en = bus.update_valid && bus.update_taken && rst_n;

    // New entry overwrites whatever sits at the index
    always_comb begin
        wr_entry.valid  = 1'b1;
        wr_entry.tag    = bus.update_pc[`BP_TAG_LSB +: `BP_TAG_W];
        wr_entry.target = bus.update_target[`BP_ADDR_W-1 -: `BP_TARGET_W];  // Drop byte bits
    end

    branch_predictor_ram #(
        .payload_t (bp_pkg::btb_entry_t)
    ) btb_ram (
        .clk        (clk),
        .write_addr (wr_index),
        .write_en   (wr_en),
        .read_addr  (rd_index),
        .read_en    (bus.fetch_valid),
        .write_data (wr_entry),
        .read_data  (rd_entry)
    );

    // Tag follows the RAM read by one cycle, holds with it
    always_ff @(posedge clk) begin
        if (bus.fetch_valid) begin
            fetch_tag_q <= fetch_tag;
        end
    end

    // Hit needs a written entry from the same tag
    assign btb_hit = rd_entry.valid && (rd_entry.tag == fetch_tag_q);

    // Back to a byte address
    assign btb_target = {rd_entry.target, {(`BP_ADDR_W - `BP_TARGET_W){1'b0}}};

endmodule

// ==== hw/direction_table.sv ====
// Direction counter table
`timescale 1ns/100ps
`include "bp_defs.svh"

module direction_table (
    input  logic             clk,
    input  logic             rst_n,
    bp_if.tbl                bus,
    output bp_pkg::counter_t dir_counter
);

    logic [`BP_INDEX_W-1:0] rd_index;       // Lookup row
    logic [`BP_INDEX_W-1:0] wr_index;       // Update row
    logic                   wr_en;
    bp_pkg::counter_t       next_counter;   // Saturated step of reported counter

    assign rd_index = bus.fetch_pc[`BP_INDEX_LSB +: `BP_INDEX_W];
    assign wr_index = bus.update_pc[`BP_INDEX_LSB +: `BP_INDEX_W];

    // Every resolved branch trains its counter, none during reset
    assign wr_en = bus.update_valid && rst_n;

    // Step from the counter reported at prediction time
    // Saves a second read port on the table
    always_comb begin
        next_counter = bus.update_counter;                  // Hold at the rails
        if (bus.update_taken) begin
            if (bus.update_counter != 2'd3) begin
                next_counter = bus.update_counter + 2'd1;   // Toward strongly taken
            end
        end else begin
            if (bus.update_counter != 2'd0) begin
                next_counter = bus.update_counter - 2'd1;   // Toward strongly not taken
            end
        end
    end

    branch_predictor_ram #(
        .payload_t (bp_pkg::counter_t)
    ) dir_ram (
        .clk        (clk),
        .write_addr (wr_index),
        .write_en   (wr_en),
        .read_addr  (rd_index),
        .read_en    (bus.fetch_valid),
        .write_data (next_counter),
        .read_data  (dir_counter)       // Valid the cycle after lookup
    );

endmodule

// ==== hw/prediction_merge.sv ====
// Prediction merge stage
`timescale 1ns/100ps
`include "bp_defs.svh"

module prediction_merge (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  fetch_valid,
    input  logic [`BP_ADDR_W-1:0] fetch_pc,
    input  logic                  btb_hit,
    input  logic [`BP_ADDR_W-1:0] btb_target,
    input  bp_pkg::counter_t      dir_counter,
    output logic                  pred_valid,
    output logic                  pred_hit,
    output logic                  pred_taken,
    output logic [`BP_ADDR_W-1:0] pred_target,
    output bp_pkg::counter_t      pred_counter
);

    localparam logic [`BP_ADDR_W-1:0] INSTR_BYTES = 4;     // Sequential fetch step

    logic [`BP_ADDR_W-1:0] fetch_pc_q;      // Lookup pc aligned with table outputs

    // Strobe tracks the RAM read latency
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pred_valid <= 1'b0;
        end else begin
            pred_valid <= fetch_valid;
        end
    end

    // Holds along with the RAM outputs
    always_ff @(posedge clk) begin
        if (fetch_valid) begin
            fetch_pc_q <= fetch_pc;
        end
    end

    assign pred_hit     = btb_hit;
    assign pred_taken   = btb_hit && dir_counter[1];   // Upper bit is the direction
    assign pred_counter = dir_counter;                 // Returned with the update later

    // Known branch uses its target, anything else falls through
    assign pred_target = btb_hit ? btb_target : fetch_pc_q + INSTR_BYTES;

endmodule

// ==== hw/branch_predictor.sv ====
// Branch predictor top
`timescale 1ns/100ps
`include "bp_defs.svh"

module branch_predictor (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  fetch_valid,
    input  logic [`BP_ADDR_W-1:0] fetch_pc,
    input  logic                  update_valid,
    input  logic [`BP_ADDR_W-1:0] update_pc,
    input  logic                  update_taken,
    input  logic [`BP_ADDR_W-1:0] update_target,
    input  logic [1:0]            update_counter,
    output logic                  pred_valid,
    output logic                  pred_hit,
    output logic                  pred_taken,
    output logic [`BP_ADDR_W-1:0] pred_target,
    output logic [1:0]            pred_counter
);

    logic                  btb_hit;
    logic [`BP_ADDR_W-1:0] btb_target;
    bp_pkg::counter_t      dir_counter;

    bp_if bus0 ();      // Shared lookup and update bus

    // Ports onto the bus
    assign bus0.fetch_valid    = fetch_valid;
    assign bus0.fetch_pc       = fetch_pc;
    assign bus0.update_valid   = update_valid;
    assign bus0.update_pc      = update_pc;
    assign bus0.update_taken   = update_taken;
    assign bus0.update_target  = update_target;
    assign bus0.update_counter = update_counter;

    btb_lookup btb0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .bus        (bus0),
        .btb_hit    (btb_hit),
        .btb_target (btb_target)
    );

    direction_table dir0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .bus         (bus0),
        .dir_counter (dir_counter)
    );

    prediction_merge merge0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .fetch_valid  (fetch_valid),
        .fetch_pc     (fetch_pc),
        .btb_hit      (btb_hit),
        .btb_target   (btb_target),
        .dir_counter  (dir_counter),
        .pred_valid   (pred_valid),
        .pred_hit     (pred_hit),
        .pred_taken   (pred_taken),
        .pred_target  (pred_target),
        .pred_counter (pred_counter)
    );

endmodule

// ==== testbench/branch_predictor_properties.sv ====
// Prediction timing assertions
`timescale 1ns/100ps

module branch_predictor_properties (
    input logic clk,
    input logic rst_n,
    input logic fetch_valid,
    input logic pred_valid,
    input logic pred_hit,
    input logic pred_taken
);

    int fail_count = 0;     // Failed assertions so far

    // One cycle lookup latency
    valid_follows_fetch: assert property (@(posedge clk) disable iff (!rst_n)
        $past(rst_n) |-> (pred_valid == $past(fetch_valid)))
        else begin
            fail_count++;
            $error("pred_valid does not follow fetch_valid by one cycle");
        end

    // Only a known branch predicts taken
    taken_needs_hit: assert property (@(posedge clk) disable iff (!rst_n)
        (pred_valid && pred_taken) |-> pred_hit)
        else begin
            fail_count++;
            $error("pred_taken high without pred_hit");
        end

    // Strobe cleared by reset
    valid_low_in_reset: assert property (@(posedge clk) !rst_n |=> !pred_valid)
        else begin
            fail_count++;
            $error("pred_valid high while in reset");
        end

endmodule

bind branch_predictor branch_predictor_properties props0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .fetch_valid (fetch_valid),
    .pred_valid  (pred_valid),
    .pred_hit    (pred_hit),
    .pred_taken  (pred_taken)
);

// ==== testbench/tb_branch_predictor.sv ====
// Branch predictor testbench
`timescale 1ns/100ps
`include "bp_defs.svh"

module tb_branch_predictor;

    localparam int          CLK_PERIOD   = 100;
    localparam int          RESET_CYCLES = 16;
    localparam int          RANDOM_ROWS  = 48;
    localparam logic [1:0]  LOOKUP       = 2'd1;
    localparam logic [1:0]  UPDATE       = 2'd2;
    localparam logic [1:0]  BOTH         = 2'd3;
    localparam logic [31:0] PC_A         = 32'h0000_1040;   // Index 0x010, tag 2
    localparam logic [31:0] PC_A2        = 32'h0000_1840;   // Same index, tag 3
    localparam logic [31:0] PC_B         = 32'h0000_2100;   // Index 0x040, tag 4
    localparam logic [31:0] PC_B2        = 32'h0000_2900;   // Same index, tag 5
    localparam logic [31:0] PC_C         = 32'h0000_3000;   // Never trained

    typedef struct packed {
        logic [1:0]       op;           // Bit 0 lookup, bit 1 update
        logic [31:0]      pc;
        logic             taken;
        logic [31:0]      target;
        bp_pkg::counter_t counter;      // From last prediction for pc
        logic             exp_hit;
        logic             exp_taken;
        logic [31:0]      exp_target;
        bp_pkg::counter_t exp_counter;
    } row_t;

    logic clk;
    logic rst_n;
    logic fetch_valid;
    logic [`BP_ADDR_W-1:0] fetch_pc;
    logic update_valid;
    logic [`BP_ADDR_W-1:0] update_pc;
    logic update_taken;
    logic [`BP_ADDR_W-1:0] update_target;
    logic [1:0] update_counter;
    logic pred_valid;
    logic pred_hit;
    logic pred_taken;
    logic [`BP_ADDR_W-1:0] pred_target;
    logic [1:0] pred_counter;

    logic                   m_valid  [`BP_DEPTH];   // Reference target table
    logic [`BP_TAG_W-1:0]   m_tag    [`BP_DEPTH];
    logic [31:0]            m_target [`BP_DEPTH];
    bp_pkg::counter_t       m_cnt    [`BP_DEPTH];   // Reference counters
    row_t                   rows [$];
    int                     checks      = 0;
    int                     errors      = 0;
    logic                   table_ready = 1'b0;

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    branch_predictor dut0 (.*);

    function automatic bp_pkg::counter_t saturate_step(bp_pkg::counter_t c, logic taken);
        if (taken) begin
            return (c == 2'd3) ? c : c + 2'd1;
        end
        return (c == 2'd0) ? c : c - 2'd1;
    endfunction

    // Counter the fetch unit would report back with its update
    function automatic bp_pkg::counter_t last_counter(logic [31:0] pc, int upto);
        for (int j = upto - 1; j >= 0; j--) begin
            if (rows[j].op[0] && rows[j].pc == pc) begin
                return rows[j].exp_counter;
            end
        end
        return 2'd0;                                    // Never looked up
    endfunction

    task automatic add_row(input logic [1:0] op, input logic [31:0] pc, input logic taken,
                           input logic [31:0] target);
        row_t r;
        r        = '0;
        r.op     = op;
        r.pc     = pc;
        r.taken  = taken;
        r.target = target;
        rows.push_back(r);
    endtask

    task automatic add_update_then_lookup(input logic [31:0] pc, input logic taken,
                                          input logic [31:0] target);
        add_row(UPDATE, pc, taken, target);
        add_row(LOOKUP, pc, 1'b0, '0);                  // Sees the new contents
    endtask

    // Walks the table in order, lookups see state before the same row's update
    task automatic build_expected();
        row_t r;
        int   idx;
        m_valid  = '{default: 1'b0};
        m_tag    = '{default: '0};
        m_target = '{default: '0};
        m_cnt    = '{default: 2'd0};
        for (int i = 0; i < rows.size(); i++) begin
            r         = rows[i];
            idx       = r.pc[`BP_INDEX_LSB +: `BP_INDEX_W];
            r.counter = last_counter(r.pc, i);
            if (r.op[0]) begin
                r.exp_hit     = m_valid[idx] && (m_tag[idx] == r.pc[`BP_TAG_LSB +: `BP_TAG_W]);
                r.exp_taken   = r.exp_hit && m_cnt[idx][1];         // Upper bit is direction
                r.exp_target  = r.exp_hit ? m_target[idx] : r.pc + 32'd4;
                r.exp_counter = m_cnt[idx];
            end
            if (r.op[1]) begin
                m_cnt[idx] = saturate_step(r.counter, r.taken);     // Every update trains
                if (r.taken) begin
                    m_valid[idx]  = 1'b1;                           // Taken overwrites entry
                    m_tag[idx]    = r.pc[`BP_TAG_LSB +: `BP_TAG_W];
                    m_target[idx] = {r.target[31:2], 2'b00};
                end
            end
            rows[i] = r;
        end
    endtask

    task automatic drive_row(input row_t r);
        fetch_valid    = r.op[0];
        fetch_pc       = r.pc;
        update_valid   = r.op[1];
        update_pc      = r.pc;
        update_taken   = r.taken;
        update_target  = r.target;
        update_counter = r.counter;
    endtask

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s expected %0h, got %0h", $time, name, exp, got);
        end
    endtask

    initial begin
        row_t idle;
        idle = '0;
        drive_row(idle);
        rst_n = 1'b0;
        void'($urandom(32'h5374_84fe));
        add_row(LOOKUP, PC_C, 1'b0, '0);                // Cold misses
        add_row(LOOKUP, PC_A, 1'b0, '0);
        repeat (4) add_update_then_lookup(PC_A, 1'b1, 32'h8000_0124);  // Up to 3
        repeat (4) add_update_then_lookup(PC_A, 1'b0, 32'h0);          // Back to 0
        add_row(LOOKUP, PC_A2, 1'b0, '0);               // Alias misses
        add_row(LOOKUP, PC_A, 1'b0, '0);
        add_update_then_lookup(PC_A2, 1'b1, 32'h0000_9ab0);
        add_row(LOOKUP, PC_A, 1'b0, '0);                // Overwritten by alias
        add_update_then_lookup(PC_B, 1'b1, 32'h0000_4400);
        add_row(UPDATE, PC_B, 1'b1, 32'h0000_4400);
        add_row(LOOKUP, PC_B2, 1'b0, '0);               // Miss but counter 2
        add_update_then_lookup(PC_B2, 1'b0, 32'h0);
        add_row(LOOKUP, PC_B, 1'b0, '0);
        add_row(LOOKUP, PC_C, 1'b0, '0);                // Back to back lookups
        add_row(LOOKUP, PC_A, 1'b0, '0);
        add_row(LOOKUP, PC_A2, 1'b0, '0);
        add_row(LOOKUP, PC_B, 1'b0, '0);
        add_row(BOTH, PC_A2, 1'b1, 32'h0000_9ab0);      // Read first on collision
        add_row(LOOKUP, PC_A2, 1'b0, '0);
        for (int i = 0; i < RANDOM_ROWS; i++) begin
            add_row($urandom_range(1, 3), 32'h0001_0000 | ($urandom_range(0, 3) << 11)
                    | ($urandom_range(0, 7) << 2), $urandom_range(0, 1),
                    $urandom & 32'hFFFF_FFFC);
        end
        rows.push_back(idle);                           // Lets the last row be checked
        build_expected();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #10 rst_n = 1'b1;
        for (int i = 0; i < rows.size(); i++) begin
            @(posedge clk);
            #10;
            if (i > 0) begin
                compare_field("pred_valid", pred_valid, rows[i-1].op[0]);
                if (rows[i-1].op[0]) begin
                    compare_field("pred_hit", pred_hit, rows[i-1].exp_hit);
                    compare_field("pred_taken", pred_taken, rows[i-1].exp_taken);
                    compare_field("pred_target", pred_target, rows[i-1].exp_target);
                    compare_field("pred_counter", pred_counter, rows[i-1].exp_counter);
                end
            end
            drive_row(rows[i]);
        end
        $display("Summary: %0d checks, %0d errors, %0d assertion failures", checks, errors,
                 dut0.props0.fail_count);
        if (errors == 0 && dut0.props0.fail_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // Watchdog sized from the table length
    initial begin
        wait (table_ready);
        #((rows.size() + RESET_CYCLES + 20) * CLK_PERIOD);
        $display("Timeout: table not finished after %0d cycles", rows.size() + RESET_CYCLES + 20);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+include
hw/bp_pkg.sv
hw/bp_if.sv
hw/branch_predictor_ram.sv
hw/btb_lookup.sv
hw/direction_table.sv
hw/prediction_merge.sv
hw/branch_predictor.sv
testbench/branch_predictor_properties.sv
testbench/tb_branch_predictor.sv

// ==== Bender.yml ====
package:
  name: branch_predictor

sources:
  - include_dirs:
      - include
    files:
      - hw/bp_pkg.sv
      - hw/bp_if.sv
      - hw/branch_predictor_ram.sv
      - hw/btb_lookup.sv
      - hw/direction_table.sv
      - hw/prediction_merge.sv
      - hw/branch_predictor.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/branch_predictor_properties.sv
      - testbench/tb_branch_predictor.sv
